// ==== project.f ====
hdl/rvPkg.sv
hdl/immGen.sv
hdl/aluCore.sv
hdl/branchUnit.sv
hdl/lsuMem.sv
hdl/exeStage.sv
tb/exeStage_sva.sv
tb/exeStage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module exeStage_tb \
    --Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== tb/exeStage_tb.sv ====
`timescale 1ns/1ps

module exeStage_tb;
    localparam int memWords   = 256;
    localparam int numInstr   = 171;  // 3 + 76 + 18 + 6 + 24 + 44
    localparam int cycleLimit = numInstr * 8 + 100;

    logic              clk;
    logic              rstN;
    logic              req;
    rvPkg::issueReq_t  issue;
    logic              ack;
    rvPkg::exeResult_t result;
    logic [7:0]        memModel [memWords*8];
    int                errCount    = 0;
    int                checkCount  = 0;
    int                testCount   = 0;
    int                cycleCount  = 0;
    int                testErrBase = 0;

    exeStage #(.memWords(memWords)) u_exeStage (
        .clk(clk), .rstN(rstN), .req(req), .issue(issue), .ack(ack), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: no finish after %0d cycles", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // expected result straight from the RV64I rules
    function automatic rvPkg::exeResult_t refResult(input rvPkg::issueReq_t p);
        rvPkg::exeResult_t r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] iI;
        logic [63:0] iB;
        logic [63:0] iJ;
        logic [63:0] ld;
        logic [63:0] addr;
        logic [31:0] w;
        logic        taken;
        int          n;
        int          idx;
        opc = p.inst[6:0];
        f3  = p.inst[14:12];
        f7  = p.inst[31:25];
        a   = p.rs1;
        iI  = {{52{p.inst[31]}}, p.inst[31:20]};
        iB  = {{52{p.inst[31]}}, p.inst[7], p.inst[30:25], p.inst[11:8], 1'b0};
        iJ  = {{44{p.inst[31]}}, p.inst[19:12], p.inst[20], p.inst[30:21], 1'b0};
        b   = opc[5] ? p.rs2 : iI;
        r   = '0;
        r.rd = p.inst[11:7];
        case (opc)
            7'b0110011, 7'b0010011: begin
                r.wen = 1'b1;
                case (f3)
                    3'd0: r.wdata = (opc[5] && f7[5]) ? a - b : a + b;
                    3'd1: r.wdata = a << b[5:0];
                    3'd2: r.wdata = {63'b0, $signed(a) < $signed(b)};
                    3'd3: r.wdata = {63'b0, a < b};
                    3'd4: r.wdata = a ^ b;
                    3'd5: begin
                        if (f7[5]) r.wdata = $signed(a) >>> b[5:0];
                        else r.wdata = a >> b[5:0];
                    end
                    3'd6: r.wdata = a | b;
                    default: r.wdata = a & b;
                endcase
            end
            7'b0111011, 7'b0011011: begin
                r.wen = 1'b1;
                w = '0;
                case (f3)
                    3'd0: w = (opc[5] && f7[5]) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                    3'd1: w = a[31:0] << b[4:0];
                    default: begin
                        if (f7[5]) w = $signed(a[31:0]) >>> b[4:0];
                        else w = a[31:0] >> b[4:0];
                    end
                endcase
                r.wdata = {{32{w[31]}}, w};
            end
            7'b0110111: begin
                r.wen   = 1'b1;
                r.wdata = {{32{p.inst[31]}}, p.inst[31:12], 12'h0};
            end
            7'b0010111: begin
                r.wen   = 1'b1;
                r.wdata = p.pc + {{32{p.inst[31]}}, p.inst[31:12], 12'h0};
            end
            7'b1101111, 7'b1100111: begin
                r.wen      = 1'b1;
                r.wdata    = p.pc + 64'd4;
                r.redirect = 1'b1;
                r.target   = opc[3] ? p.pc + iJ : (a + iI) & ~64'd1;
            end
            7'b1100011: begin
                case (f3)
                    3'd0: taken = a == p.rs2;
                    3'd1: taken = a != p.rs2;
                    3'd4: taken = $signed(a) < $signed(p.rs2);
                    3'd5: taken = $signed(a) >= $signed(p.rs2);
                    3'd6: taken = a < p.rs2;
                    default: taken = a >= p.rs2;
                endcase
                r.redirect = taken;
                r.target   = taken ? p.pc + iB : '0;
            end
            7'b0000011: begin
                r.wen = 1'b1;
                addr  = a + iI;
                n     = 1 << f3[1:0];
                ld    = '0;
                for (int i = 0; i < n; i++) begin
                    idx = int'((addr + 64'(i)) % 64'(memWords * 8));
                    ld[i*8 +: 8] = memModel[idx];
                end
                if (!f3[2] && n < 8) begin
                    for (int k = n * 8; k < 64; k++) ld[k] = ld[n*8-1];  // sign fill
                end
                r.wdata = ld;
            end
            default: ;
        endcase
        r.wen = r.wen && (r.rd != 5'd0);
        return r;
    endfunction

    task automatic updateStore(input rvPkg::issueReq_t p);
        logic [63:0] addr;
        int          n;
        int          idx;
        if (p.inst[6:0] == 7'b0100011) begin
            addr = p.rs1 + {{52{p.inst[31]}}, p.inst[31:25], p.inst[11:7]};
            n    = 1 << p.inst[13:12];
            for (int i = 0; i < n; i++) begin
                idx = int'((addr + 64'(i)) % 64'(memWords * 8));
                memModel[idx] = p.rs2[i*8 +: 8];
            end
        end
    endtask

    task automatic checkEq(input string name, input logic [63:0] exp, input logic [63:0] got);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    // runs one four-phase handshake and keeps req high for hold extra cycles after ack
    task automatic issueOne(input rvPkg::issueReq_t p, input int hold,
                            output rvPkg::exeResult_t r);
        int cycles;
        @(negedge clk);
        issue  = p;
        req    = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < 10);
        assert (ack) else begin
            errCount++;
            $display("ack never rose after req");
        end
        assert (cycles == 3) else begin
            errCount++;
            $display("ack rose %0d cycles after req was sampled, not 2", cycles - 1);
        end
        r = result;
        repeat (hold) begin
            @(negedge clk);
            assert (ack && result == r) else begin
                errCount++;
                $display("ack or result changed while req was held");
            end
        end
        req = 1'b0;
        @(negedge clk);
        assert (!ack) else begin
            errCount++;
            $display("ack did not fall one cycle after req dropped");
        end
    endtask

    task automatic runOne(input logic [31:0] inst, input logic [63:0] rs1v,
                          input logic [63:0] rs2v, input int hold);
        rvPkg::issueReq_t  p;
        rvPkg::exeResult_t exp;
        rvPkg::exeResult_t got;
        p.pc   = {$urandom(), $urandom()} & ~64'h3;
        p.inst = inst;
        p.rs1  = rs1v;
        p.rs2  = rs2v;
        exp = refResult(p);
        issueOne(p, hold, got);
        checkEq("result.wen", 64'(exp.wen), 64'(got.wen));
        checkEq("result.rd", 64'(exp.rd), 64'(got.rd));
        checkEq("result.wdata", exp.wdata, got.wdata);
        checkEq("result.redirect", 64'(exp.redirect), 64'(got.redirect));
        checkEq("result.target", exp.target, got.target);
        updateStore(p);
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("%s done, %0d errors", name, errCount - testErrBase);
        testErrBase = errCount;
    endtask

    task automatic handshakeTest;
        checkEq("ack", 64'd0, 64'(ack));
        checkEq("result", '0, result.wdata | result.target |
                64'({result.wen, result.rd, result.redirect}));
        for (int h = 1; h <= 3; h++) begin
            runOne(encI(12'($urandom()), 3'd0, 5'd3, rvPkg::opOpImm), {$urandom(), $urandom()},
                   '0, h);
        end
        finishTest("handshake");
    endtask

    task automatic aluTest;
        logic [2:0]  rf3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic [6:0]  rf7 [10] = '{0, 7'h20, 0, 0, 0, 0, 0, 7'h20, 0, 0};
        logic [2:0]  if3 [6]  = '{0, 2, 3, 4, 6, 7};
        int          amts [4] = '{0, 31, 32, 63};
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        for (int i = 0; i < 10; i++) begin
            for (int k = 0; k < 4; k++) begin
                a = {$urandom(), $urandom()};
                b = {$urandom(), $urandom()};
                if (k == 1) b = a;
                if (k == 2) a[63] = ~b[63];  // signs differ
                if (rf3[i] == 3'd1 || rf3[i] == 3'd5) b[5:0] = 6'(amts[k]);
                runOne(encR(rf7[i], rf3[i], 5'(1 + k * 7), rvPkg::opOp), a, b, 0);
            end
        end
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 6; i++) begin
                runOne(encI(12'($urandom()), if3[i], 5'(2 + i), rvPkg::opOpImm),
                       {$urandom(), $urandom()}, '0, 0);
            end
            sh = 6'(amts[k]);
            a  = {$urandom(), $urandom()};
            runOne(encI({6'h00, sh}, 3'd1, 5'd9, rvPkg::opOpImm), a, '0, 0);
            runOne(encI({6'h00, sh}, 3'd5, 5'd9, rvPkg::opOpImm), a, '0, 0);
            runOne(encI({6'h10, sh}, 3'd5, 5'd9, rvPkg::opOpImm), a, '0, 0);
        end
        finishTest("alu");
    endtask

    task automatic wordTest;
        logic [63:0] a;
        logic [63:0] b;
        for (int s = 0; s < 2; s++) begin
            a = (s == 0) ? {$urandom(), 32'h8000_0f00} : {$urandom(), 32'h1234_5678};
            b = (s == 0) ? {$urandom(), 32'd4} : {$urandom(), 32'd3};
            runOne(encR(7'h00, 3'd0, 5'd4, rvPkg::opOp32), a, b, 0);
            runOne(encR(7'h20, 3'd0, 5'd4, rvPkg::opOp32), a, b, 0);
            runOne(encR(7'h00, 3'd1, 5'd4, rvPkg::opOp32), a, b, 0);
            runOne(encR(7'h00, 3'd5, 5'd4, rvPkg::opOp32), a, b, 0);
            runOne(encR(7'h20, 3'd5, 5'd4, rvPkg::opOp32), a, b, 0);
            runOne(encI(12'($urandom()), 3'd0, 5'd5, rvPkg::opOpImm32), a, '0, 0);
            runOne(encI({7'h00, 5'(4 + s)}, 3'd1, 5'd5, rvPkg::opOpImm32), a, '0, 0);
            runOne(encI({7'h00, 5'(4 + s)}, 3'd5, 5'd5, rvPkg::opOpImm32), a, '0, 0);
            runOne(encI({7'h20, 5'(4 + s)}, 3'd5, 5'd5, rvPkg::opOpImm32), a, '0, 0);
        end
        finishTest("word");
    endtask

    task automatic jumpTest;
        logic [20:0] j;
        logic [11:0] imm;
        j   = 21'($urandom()) & ~21'h1;
        imm = 12'($urandom()) & ~12'h1;
        runOne({20'($urandom()), 5'd5, rvPkg::opLui}, '0, '0, 0);
        runOne({20'($urandom()), 5'd6, rvPkg::opAuipc}, '0, '0, 0);
        runOne(encJ(j, 5'd1), '0, '0, 0);
        runOne(encI(imm, 3'd0, 5'd1, rvPkg::opJalr), {$urandom(), $urandom()} | 64'd1, '0, 0);
        runOne(encJ(j, 5'd0), '0, '0, 0);  // x0 link is never written
        runOne(encI(imm, 3'd0, 5'd0, rvPkg::opJalr), {$urandom(), $urandom()}, '0, 0);
        finishTest("jump");
    endtask

    task automatic branchTest;
        logic [2:0]  bf3 [6] = '{0, 1, 4, 5, 6, 7};
        logic [63:0] x;
        logic [63:0] y;
        for (int i = 0; i < 6; i++) begin
            x = {32'h0, $urandom() >> 1};
            y = {1'b1, 31'($urandom()), $urandom()};
            runOne(encB(13'($urandom()) & ~13'h1, bf3[i]), x, x, 0);
            runOne(encB(13'($urandom()) & ~13'h1, bf3[i]), x, x + 64'd5, 0);
            runOne(encB(13'($urandom()) & ~13'h1, bf3[i]), x + 64'd5, x, 0);
            runOne(encB(13'($urandom()) & ~13'h1, bf3[i]), y, x, 0);
        end
        finishTest("branch");
    endtask

    task automatic memTest;
        logic [63:0] base;
        logic [11:0] off;
        base = {$urandom(), $urandom()} & ~64'h7;  // high bits wrap away
        for (int s = 0; s < 4; s++) begin
            off = 12'(s * 24);
            runOne(encS(off, 3'd3), base, {$urandom(), $urandom()}, 0);
            runOne(encS(off + 12'((s * 3) % 8), 3'd0), base, {$urandom(), $urandom()}, 0);
            runOne(encS(off + 12'(2 * (s % 4)), 3'd1), base, {$urandom(), $urandom()}, 0);
            runOne(encS(off + 12'(4 * (s % 2)), 3'd2), base, {$urandom(), $urandom()}, 0);
            runOne(encI(off + 12'((s * 5) % 8), 3'd0, 5'd10, rvPkg::opLoad), base, '0, 0);
            runOne(encI(off + 12'((s * 5) % 8), 3'd4, 5'd10, rvPkg::opLoad), base, '0, 0);
            runOne(encI(off + 12'(2 * ((s + 1) % 4)), 3'd1, 5'd11, rvPkg::opLoad), base, '0, 0);
            runOne(encI(off + 12'(2 * ((s + 1) % 4)), 3'd5, 5'd11, rvPkg::opLoad), base, '0, 0);
            runOne(encI(off + 12'(4 * ((s + 1) % 2)), 3'd2, 5'd12, rvPkg::opLoad), base, '0, 0);
            runOne(encI(off + 12'(4 * ((s + 1) % 2)), 3'd6, 5'd12, rvPkg::opLoad), base, '0, 0);
            runOne(encI(off, 3'd3, 5'd13, rvPkg::opLoad), base, '0, 0);
        end
        finishTest("memory");
    endtask

    initial begin
        void'($urandom(32'he0f7_cabf));
        rstN  = 1'b0;
        req   = 1'b0;
        issue = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        handshakeTest();
        aluTest();
        wordTest();
        jumpTest();
        branchTest();
        memTest();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/exeStage_sva.sv ====
`timescale 1ns/1ps

module exeStageSva (
    input logic               clk,
    input logic               rstN,
    input logic               req,
    input logic               ack,
    input rvPkg::exeResult_t  result,
    input rvPkg::stageState_e state
);

    // ack only answers a pending request
    ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req) && state == rvPkg::stRespond)
        else $error("ack rose without req");

    resultHeld: assert property (@(posedge clk) disable iff (!rstN)
        ack && $past(ack) |-> result == $past(result))
        else $error("result changed while ack high");

    ackFallAfterReqLow: assert property (@(posedge clk) disable iff (!rstN)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req still high");

endmodule

bind exeStage exeStageSva u_exeStageSva (
    .clk(clk), .rstN(rstN), .req(req), .ack(ack), .result(result), .state(state)
);

// ==== hdl/exeStage.sv ====
`timescale 1ns/1ps

module exeStage #(
    parameter int memWords = 256
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              req,
    input  rvPkg::issueReq_t  issue,
    output logic              ack,
    output rvPkg::exeResult_t result
);
    rvPkg::stageState_e state;
    rvPkg::issueReq_t   pkt;
    rvPkg::decoded_t    dec;
    rvPkg::exeResult_t  merged;
    logic               memDone;
    logic               start;
    logic               aluWen;
    logic [63:0]        aluValue;
    logic               redirect;
    logic [63:0]        target;
    logic [63:0]        loadData;

    assign start = (state == rvPkg::stExec) && !memDone;  // one pulse per instruction

    always_ff @(posedge clk) begin
        if (state == rvPkg::stIdle && req) pkt <= issue;
    end

    immGen u_immGen (.inst(pkt.inst), .dec(dec));

    aluCore u_aluCore (
        .pc(pkt.pc), .rs1(pkt.rs1), .rs2(pkt.rs2), .dec(dec),
        .wen(aluWen), .value(aluValue)
    );

    branchUnit u_branchUnit (
        .pc(pkt.pc), .rs1(pkt.rs1), .rs2(pkt.rs2), .dec(dec),
        .redirect(redirect), .target(target)
    );

    lsuMem #(.memWords(memWords)) u_lsuMem (
        .clk(clk), .rstN(rstN), .start(start),
        .rs1(pkt.rs1), .rs2(pkt.rs2), .dec(dec), .loadData(loadData)
    );

    always_comb begin
        merged.wen      = aluWen;
        merged.rd       = dec.rd;
        merged.wdata    = (dec.opcode == rvPkg::opLoad) ? loadData : aluValue;
        merged.redirect = redirect;
        merged.target   = target;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= rvPkg::stIdle;
            ack     <= 1'b0;
            memDone <= 1'b0;
            result  <= '0;
        end else begin
            case (state)
                rvPkg::stIdle: if (req) state <= rvPkg::stExec;
                rvPkg::stExec: begin
                    if (!memDone) begin
                        memDone <= 1'b1;  // lsu access happens this edge
                    end else begin
                        memDone <= 1'b0;
                        result  <= merged;
                        ack     <= 1'b1;
                        state   <= rvPkg::stRespond;
                    end
                end
                rvPkg::stRespond: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= rvPkg::stIdle;
                    end
                end
                default: state <= rvPkg::stIdle;
            endcase
        end
    end

endmodule

// ==== hdl/lsuMem.sv ====
`timescale 1ns/1ps

module lsuMem #(
    parameter int memWords = 256
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    input  logic [63:0]     rs1,
    input  logic [63:0]     rs2,
    input  rvPkg::decoded_t dec,
    output logic [63:0]     loadData
);
    localparam int idxW = $clog2(memWords);

    logic [63:0]     mem [memWords];
    logic            isStore;
    logic [63:0]     addr;
    logic [2:0]      offset;
    logic [idxW-1:0] wordIdx;
    logic [7:0]      baseMask;
    logic [7:0]      byteMask;
    logic [63:0]     laneData;
    logic            storeEn;
    logic            loadEn;
    logic [63:0]     rdWord;
    logic [63:0]     shifted;

    assign isStore = dec.opcode == rvPkg::opStore;
    assign addr    = rs1 + (isStore ? dec.immS : dec.immI);
    assign offset  = addr[2:0];
    assign wordIdx = addr[3 +: idxW];  // wraps modulo memory size

    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   baseMask = 8'h01;  // sb
            2'b01:   baseMask = 8'h03;  // sh
            2'b10:   baseMask = 8'h0f;  // sw
            default: baseMask = 8'hff;  // sd
        endcase
    end

    assign byteMask = baseMask << offset;
    assign laneData = rs2 << {offset, 3'b000};
    assign storeEn  = start && isStore && !dec.funct3[2];
    assign loadEn   = start && dec.opcode == rvPkg::opLoad;

    always_ff @(posedge clk) begin
        if (storeEn) begin
            for (int b = 0; b < 8; b++) begin
                if (byteMask[b]) mem[wordIdx][b*8 +: 8] <= laneData[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) rdWord <= '0;
        else if (loadEn) rdWord <= mem[wordIdx];
    end

    // addr and funct3 stay put while the packet is held
    assign shifted = rdWord >> {offset, 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  loadData = {{56{shifted[7]}}, shifted[7:0]};    // lb
            3'b001:  loadData = {{48{shifted[15]}}, shifted[15:0]};  // lh
            3'b010:  loadData = rvPkg::sextW(shifted[31:0]);         // lw
            3'b011:  loadData = shifted;                             // ld
            3'b100:  loadData = {56'b0, shifted[7:0]};               // lbu
            3'b101:  loadData = {48'b0, shifted[15:0]};              // lhu
            3'b110:  loadData = {32'b0, shifted[31:0]};              // lwu
            default: loadData = '0;
        endcase
    end

endmodule

// ==== hdl/branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit (
    input  logic [63:0]     pc,
    input  logic [63:0]     rs1,
    input  logic [63:0]     rs2,
    input  rvPkg::decoded_t dec,
    output logic            redirect,
    output logic [63:0]     target
);
    logic taken;

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rs1 == rs2;                     // beq
            3'b001:  taken = rs1 != rs2;                     // bne
            3'b100:  taken = $signed(rs1) < $signed(rs2);    // blt
            3'b101:  taken = $signed(rs1) >= $signed(rs2);   // bge
            3'b110:  taken = rs1 < rs2;                      // bltu
            3'b111:  taken = rs1 >= rs2;                     // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect = 1'b0;
        target   = '0;
        case (dec.opcode)
            rvPkg::opBranch: begin
                redirect = taken;
                target   = taken ? pc + dec.immB : '0;
            end
            rvPkg::opJal: begin
                redirect = 1'b1;
                target   = pc + dec.immJ;
            end
            rvPkg::opJalr: begin
                redirect = dec.funct3 == 3'b000;
                target   = (dec.funct3 == 3'b000) ? (rs1 + dec.immI) & ~64'd1 : '0;
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/aluCore.sv ====
`timescale 1ns/1ps

module aluCore (
    input  logic [63:0]     pc,
    input  logic [63:0]     rs1,
    input  logic [63:0]     rs2,
    input  rvPkg::decoded_t dec,
    output logic            wen,
    output logic [63:0]     value
);
    logic          isReg;
    logic          isWord;
    logic [63:0]   opB;
    rvPkg::aluOp_e aluOp;
    logic [63:0]   res64;
    logic [31:0]   res32;
    logic          wenRaw;

    assign isReg  = dec.opcode inside {rvPkg::opOp, rvPkg::opOp32};
    assign isWord = dec.opcode inside {rvPkg::opOpImm32, rvPkg::opOp32};
    assign opB    = isReg ? rs2 : dec.immI;
    assign aluOp  = rvPkg::decodeAluOp(dec.funct3, dec.funct7, isReg, isWord);

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:  res64 = rs1 + opB;
            rvPkg::aluSub:  res64 = rs1 - opB;
            rvPkg::aluSll:  res64 = rs1 << opB[5:0];
            rvPkg::aluSlt:  res64 = {63'b0, $signed(rs1) < $signed(opB)};
            rvPkg::aluSltu: res64 = {63'b0, rs1 < opB};
            rvPkg::aluXor:  res64 = rs1 ^ opB;
            rvPkg::aluSrl:  res64 = rs1 >> opB[5:0];
            rvPkg::aluSra:  res64 = $signed(rs1) >>> opB[5:0];
            rvPkg::aluOr:   res64 = rs1 | opB;
            rvPkg::aluAnd:  res64 = rs1 & opB;
            default:        res64 = '0;
        endcase
    end

    // W forms work on the low word only
    always_comb begin
        case (aluOp)
            rvPkg::aluAdd: res32 = rs1[31:0] + opB[31:0];
            rvPkg::aluSub: res32 = rs1[31:0] - opB[31:0];
            rvPkg::aluSll: res32 = rs1[31:0] << opB[4:0];
            rvPkg::aluSrl: res32 = rs1[31:0] >> opB[4:0];
            rvPkg::aluSra: res32 = $signed(rs1[31:0]) >>> opB[4:0];
            default:       res32 = '0;
        endcase
    end

    always_comb begin
        wenRaw = 1'b0;
        value  = '0;
        case (dec.opcode)
            rvPkg::opLoad: wenRaw = 1'b1;  // data comes from lsu
            rvPkg::opOpImm, rvPkg::opOp: begin
                wenRaw = aluOp != rvPkg::aluIllegal;
                value  = res64;
            end
            rvPkg::opOpImm32, rvPkg::opOp32: begin
                wenRaw = aluOp != rvPkg::aluIllegal;
                value  = rvPkg::sextW(res32);
            end
            rvPkg::opLui: begin
                wenRaw = 1'b1;
                value  = dec.immU;
            end
            rvPkg::opAuipc: begin
                wenRaw = 1'b1;
                value  = pc + dec.immU;
            end
            rvPkg::opJal: begin
                wenRaw = 1'b1;
                value  = pc + 64'd4;  // link
            end
            rvPkg::opJalr: begin
                wenRaw = dec.funct3 == 3'b000;
                value  = pc + 64'd4;
            end
            default: ;
        endcase
    end

    assign wen = wenRaw && (dec.rd != 5'd0);  // x0 never written

endmodule

// ==== hdl/immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  logic [31:0]     inst,
    output rvPkg::decoded_t dec
);
    logic        sign;
    logic [63:0] immI;
    logic [63:0] immS;
    logic [63:0] immB;
    logic [63:0] immU;
    logic [63:0] immJ;

    assign sign = inst[31];

    assign immI = {{52{sign}}, inst[31:20]};
    assign immS = {{52{sign}}, inst[31:25], inst[11:7]};
    assign immB = {{51{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{sign}}, inst[31:12], 12'b0};
    assign immJ = {{43{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec.opcode = rvPkg::opcode_e'(inst[6:0]);  // unknown codes pass through raw
        dec.funct3 = inst[14:12];
        dec.funct7 = inst[31:25];
        dec.rd     = inst[11:7];
        dec.immI   = immI;
        dec.immS   = immS;
        dec.immB   = immB;
        dec.immU   = immU;
        dec.immJ   = immJ;
    end

endmodule

// ==== hdl/rvPkg.sv ====
package rvPkg;

    typedef enum logic [6:0] {
        opLoad    = 7'b0000011,
        opStore   = 7'b0100011,
        opBranch  = 7'b1100011,
        opJal     = 7'b1101111,
        opJalr    = 7'b1100111,
        opOpImm   = 7'b0010011,
        opOpImm32 = 7'b0011011,
        opOp      = 7'b0110011,
        opOp32    = 7'b0111011,
        opLui     = 7'b0110111,
        opAuipc   = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd, aluIllegal
    } aluOp_e;

    typedef enum logic [1:0] {
        stIdle, stExec, stRespond
    } stageState_e;

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] inst;
        logic [63:0] rs1;
        logic [63:0] rs2;
    } issueReq_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rd;
        logic [63:0] immI;
        logic [63:0] immS;
        logic [63:0] immB;
        logic [63:0] immU;
        logic [63:0] immJ;
    } decoded_t;

    typedef struct packed {
        logic        wen;
        logic [4:0]  rd;
        logic [63:0] wdata;
        logic        redirect;
        logic [63:0] target;
    } exeResult_t;

    function automatic logic [63:0] sextW(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // isReg selects the register form and isWord the 32-bit W form
    function automatic aluOp_e decodeAluOp(input logic [2:0] funct3, input logic [6:0] funct7,
                                           input logic isReg, input logic isWord);
        logic [6:0] f7;
        aluOp_e     op;
        f7 = (!isReg && !isWord) ? {funct7[6:1], 1'b0} : funct7;  // bit 25 is shamt[5]
        op = aluIllegal;
        case (funct3)
            3'b000: begin
                if (!isReg || f7 == 7'h00) op = aluAdd;
                else if (f7 == 7'h20) op = aluSub;
            end
            3'b001: if (f7 == 7'h00) op = aluSll;
            3'b010: if (!isWord && (!isReg || f7 == 7'h00)) op = aluSlt;
            3'b011: if (!isWord && (!isReg || f7 == 7'h00)) op = aluSltu;
            3'b100: if (!isWord && (!isReg || f7 == 7'h00)) op = aluXor;
            3'b101: begin
                if (f7 == 7'h00) op = aluSrl;
                else if (f7 == 7'h20) op = aluSra;
            end
            3'b110: if (!isWord && (!isReg || f7 == 7'h00)) op = aluOr;
            default: if (!isWord && (!isReg || f7 == 7'h00)) op = aluAnd;
        endcase
        return op;
    endfunction

endpackage
